// ==== compile.f ====
hw/squeeze_pkg.sv
hw/fetch_if.sv
hw/cmd_queue.sv
hw/op_dispatcher.sv
hw/fetch_channel.sv
hw/layer_engine.sv
hw/squeeze_top.sv
verification/squeeze_checker.sv
verification/squeeze_tb.sv

// ==== Bender.yml ====
package:
  name: squeeze

sources:
  - hw/squeeze_pkg.sv
  - hw/fetch_if.sv
  - hw/cmd_queue.sv
  - hw/op_dispatcher.sv
  - hw/fetch_channel.sv
  - hw/layer_engine.sv
  - hw/squeeze_top.sv
  - target: simulation
    files:
      - verification/squeeze_checker.sv
      - verification/squeeze_tb.sv

// ==== verification/squeeze_tb.sv ====
`timescale 1ns/1ps

module squeeze_tb;
	import squeeze_pkg::*;

	localparam int CLK_NS   = 40;
	localparam int N_CONV   = 30;
	localparam int N_MAX    = 20;
	localparam int NEG_BASE = 512;             // data run holding only negative words
	localparam int NEG_LEN  = 64;

	logic    okClk;
	logic    rst_n;
	logic    mem_we;
	logic    mem_bank;
	addr_t   mem_addr;
	word_t   mem_wdata;
	logic    cmd_valid;
	cmd_t    cmd_data;
	logic    cmd_full;
	logic    busy;
	logic    cmd_error;
	logic    result_valid;
	result_t result_data;

	integer  seed = 32'hae49_2262;
	word_t   data_mem [BANK_DEPTH];            // model copy of bank 0
	word_t   wt_mem   [BANK_DEPTH];            // model copy of bank 1
	bit      exp_err  [$];                     // expected events in order, 1 = cmd_error
	result_t exp_val  [$];
	longint  budget_ns   = 0;
	longint  watch_start = 0;
	bit      armed       = 1'b0;

	squeeze_top DUT (
		.okClk        (okClk),
		.rst_n        (rst_n),
		.mem_we       (mem_we),
		.mem_bank     (mem_bank),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.cmd_valid    (cmd_valid),
		.cmd_data     (cmd_data),
		.cmd_full     (cmd_full),
		.busy         (busy),
		.cmd_error    (cmd_error),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

	initial begin
		okClk = 1'b0;
		forever #(CLK_NS / 2) okClk = ~okClk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp));
		end
	endtask

	task automatic step();
		@(posedge okClk);
		#2;                                    // drive away from the edge
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic cmd_t make_cmd(input logic [1:0] op, input int len, input int da,
	                                  input int wa);
		cmd_t c;
		c = '0;
		c[OP_MSB:OP_LSB]       = op;
		c[LEN_MSB:LEN_LSB]     = len_t'(len);
		c[DADDR_MSB:DADDR_LSB] = addr_t'(da);
		c[WADDR_MSB:WADDR_LSB] = addr_t'(wa);
		return c;
	endfunction

	function automatic result_t conv_ref(input int da, input int wa, input int len);
		int acc;
		int dv;
		int wv;
		acc = 0;
		for (int i = 0; i < len; i++) begin
			dv = $signed(data_mem[(da + i) % BANK_DEPTH]);   // runs wrap past the top
			wv = $signed(wt_mem[(wa + i) % BANK_DEPTH]);
			acc += dv * wv;
		end
		return result_t'(acc);
	endfunction

	function automatic result_t max_ref(input int da, input int len);
		int best;
		int dv;
		best = $signed(data_mem[da]);
		for (int i = 1; i < len; i++) begin
			dv = $signed(data_mem[(da + i) % BANK_DEPTH]);
			if (dv > best) best = dv;
		end
		return result_t'(best);
	endfunction

	task automatic record_expect(input cmd_t c);
		int op;
		int len;
		int da;
		int wa;
		op  = c[OP_MSB:OP_LSB];
		len = c[LEN_MSB:LEN_LSB];
		da  = c[DADDR_MSB:DADDR_LSB];
		wa  = c[WADDR_MSB:WADDR_LSB];
		exp_err.push_back(op > 1 || len == 0);
		if (op > 1 || len == 0) exp_val.push_back('0);
		else if (op == 0) exp_val.push_back(conv_ref(da, wa, len));
		else exp_val.push_back(max_ref(da, len));
	endtask

	task automatic issue_cmd(input cmd_t c);
		step();
		while (cmd_full) step();               // host never writes into a full queue
		cmd_valid = 1'b1;
		cmd_data  = c;
		budget_ns += (c[LEN_MSB:LEN_LSB] + 10) * CLK_NS;
		record_expect(c);
		step();
		cmd_valid = 1'b0;
	endtask

	task automatic load_banks();
		word_t w;
		for (int b = 0; b < N_CH; b++) begin
			for (int a = 0; a < BANK_DEPTH; a++) begin
				w = word_t'($random(seed));
				if (b == 0 && a >= NEG_BASE && a < NEG_BASE + NEG_LEN) begin
					w[WORD_W-1] = 1'b1;
				end
				step();
				mem_we    = 1'b1;
				mem_bank  = b[0];
				mem_addr  = addr_t'(a);
				mem_wdata = w;
				if (b == 0) data_mem[a] = w;
				else wt_mem[a] = w;
			end
		end
		step();
		mem_we = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_err.size() != 0) step();
		step();
		step();
		check_eq("busy", busy, 0);
		check_eq("cmd_full", cmd_full, 0);
	endtask

	task automatic take_event(input bit is_err, input result_t value);
		bit      want_err;
		result_t want_val;
		if (exp_err.size() == 0) begin
			abort_run("DUT produced a result or cmd_error with no command outstanding");
		end else begin
			want_err = exp_err.pop_front();
			want_val = exp_val.pop_front();
			check_eq("cmd_error event", is_err, want_err);
			if (!is_err) check_eq("result_data", value, want_val);
		end
	endtask

	// ------------------------------------------------------------
	// monitor, watchdog, assertion watch
	// ------------------------------------------------------------
	always @(negedge okClk) begin
		if (rst_n === 1'b1) begin
			if (result_valid) take_event(1'b0, result_data);
			if (cmd_error) take_event(1'b1, '0);
		end
	end

	initial begin
		wait (armed);
		while ($time <= watch_start + budget_ns + 10_000) @(posedge okClk);
		abort_run("timeout: the DUT did not finish the issued commands in time");
	end

	initial begin
		wait (DUT.u_checker.assert_fails != 0);
		abort_run("a concurrent assertion on the top-level ports failed");
	end

	initial begin
		cmd_t c;
		int   accepted;
		bit   full_seen;
		rst_n     = 1'b0;
		mem_we    = 1'b0;
		mem_bank  = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		cmd_valid = 1'b0;
		cmd_data  = '0;
		repeat (5) @(posedge okClk);
		#2;
		rst_n = 1'b1;
		step();
		check_eq("cmd_full", cmd_full, 0);
		check_eq("busy", busy, 0);
		check_eq("cmd_error", cmd_error, 0);
		check_eq("result_valid", result_valid, 0);

		load_banks();
		watch_start = $time;
		armed       = 1'b1;

		for (int i = 0; i < N_CONV; i++) begin     // runs start near the top and wrap
			issue_cmd(make_cmd(OP_CONV, rand_range(1, 64), BANK_DEPTH - rand_range(1, 64),
			                   BANK_DEPTH - rand_range(1, 64)));
		end
		wait_idle();

		for (int i = 0; i < N_MAX; i++) begin
			if (i % 2 == 0) c = make_cmd(OP_MAXPOOL, rand_range(1, 16),
			                             NEG_BASE + rand_range(0, NEG_LEN - 16), 0);
			else c = make_cmd(OP_MAXPOOL, rand_range(1, 64), rand_range(0, BANK_DEPTH - 1),
			                  rand_range(0, BANK_DEPTH - 1));
			issue_cmd(c);
		end
		wait_idle();

		issue_cmd(make_cmd(2'd2, 8, 0, 0));
		issue_cmd(make_cmd(OP_CONV, 12, rand_range(0, 1023), rand_range(0, 1023)));
		issue_cmd(make_cmd(2'd3, 5, 100, 200));
		issue_cmd(make_cmd(OP_MAXPOOL, 20, rand_range(0, 1023), 0));
		wait_idle();

		issue_cmd(make_cmd(OP_CONV, 64, rand_range(0, 1023), rand_range(0, 1023)));
		while (!busy) step();
		accepted  = 0;
		full_seen = 1'b0;
		for (int i = 0; i < 10; i++) begin         // back-to-back writes, one per cycle
			c = make_cmd(rand_range(0, 1), rand_range(1, 16), rand_range(0, 1023),
			             rand_range(0, 1023));
			cmd_valid = 1'b1;
			cmd_data  = c;
			budget_ns += (c[LEN_MSB:LEN_LSB] + 10) * CLK_NS;
			if (cmd_full) begin
				full_seen = 1'b1;              // this write is lost
			end else begin
				record_expect(c);
				accepted++;
			end
			step();
		end
		cmd_valid = 1'b0;
		check_eq("cmd_full seen during burst", full_seen, 1);
		check_eq("accepted commands", accepted, CMD_DEPTH);
		wait_idle();

		if (DUT.u_checker.assert_fails != 0) begin
			abort_run("a concurrent assertion on the top-level ports failed");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// ==== verification/squeeze_checker.sv ====
`timescale 1ns/1ps

module squeeze_checker (
	input logic okClk,
	input logic rst_n,
	input logic busy,
	input logic cmd_error,
	input logic result_valid
);
	int assert_fails = 0;      // watched from the testbench

	// ------------------------------------------------------------
	// strobes last one cycle
	// ------------------------------------------------------------
	a_result_single: assert property (@(posedge okClk) disable iff (!rst_n)
		result_valid |=> !result_valid)
	else begin
		assert_fails++;
		$error("result_valid high in two consecutive cycles");
	end

	a_error_single: assert property (@(posedge okClk) disable iff (!rst_n)
		cmd_error |=> !cmd_error)
	else begin
		assert_fails++;
		$error("cmd_error high in two consecutive cycles");
	end

	// first edge in reset only clears the registers
	a_quiet_in_reset: assert property (@(posedge okClk)
		(!rst_n && $past(!rst_n)) |-> (!result_valid && !cmd_error))
	else begin
		assert_fails++;
		$error("result_valid or cmd_error high during reset");
	end

	a_result_when_busy: assert property (@(posedge okClk) disable iff (!rst_n)
		result_valid |-> busy)
	else begin
		assert_fails++;
		$error("result_valid while busy is low");
	end

endmodule

bind squeeze_top squeeze_checker u_checker (
	.okClk        (okClk),
	.rst_n        (rst_n),
	.busy         (busy),
	.cmd_error    (cmd_error),
	.result_valid (result_valid)
);

// ==== hw/squeeze_top.sv ====
`timescale 1ns/1ps

module squeeze_top (
	input  logic                 okClk,
	input  logic                 rst_n,
	input  logic                 mem_we,
	input  logic                 mem_bank,
	input  squeeze_pkg::addr_t   mem_addr,
	input  squeeze_pkg::word_t   mem_wdata,
	input  logic                 cmd_valid,
	input  squeeze_pkg::cmd_t    cmd_data,
	output logic                 cmd_full,
	output logic                 busy,
	output logic                 cmd_error,
	output logic                 result_valid,
	output squeeze_pkg::result_t result_data
);
	import squeeze_pkg::*;

	cmd_t     head;
	logic     empty;
	logic     pop;
	op_kind_t op_kind;

	fetch_if ch [N_CH] ();

	cmd_queue u_queue (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.push      (cmd_valid),
		.push_data (cmd_data),
		.pop       (pop),
		.head      (head),
		.empty     (empty),
		.full      (cmd_full)
	);

	op_dispatcher u_disp (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.head      (head),
		.empty     (empty),
		.pop       (pop),
		.ch        (ch),
		.op_kind   (op_kind),
		.done      (result_valid),     // result closes the operation
		.busy      (busy),
		.cmd_error (cmd_error)
	);

	// bank 0 holds data, bank 1 holds weights
	for (genvar i = 0; i < N_CH; i++) begin : g_ch
		fetch_channel u_ch (
			.okClk     (okClk),
			.rst_n     (rst_n),
			.load_we   (mem_we && (mem_bank == 1'(i))),
			.load_addr (mem_addr),
			.load_data (mem_wdata),
			.chan      (ch[i])
		);
	end

	layer_engine u_engine (
		.okClk        (okClk),
		.rst_n        (rst_n),
		.op_kind      (op_kind),
		.data         (ch[0]),
		.weight       (ch[1]),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

endmodule

// ==== hw/layer_engine.sv ====
`timescale 1ns/1ps

module layer_engine (
	input  logic                  okClk,
	input  logic                  rst_n,
	input  squeeze_pkg::op_kind_t op_kind,
	fetch_if.consume              data,
	fetch_if.consume              weight,
	output logic                  result_valid,
	output squeeze_pkg::result_t  result_data
);
	import squeeze_pkg::*;

	logic signed [2*WORD_W-1:0] prod;
	logic signed [RESULT_W-1:0] sample;
	logic signed [RESULT_W-1:0] acc;
	logic signed [RESULT_W-1:0] next_acc;
	logic                       first;      // next word opens a new operation
	logic                       take;
	logic                       take_last;

	// max pool runs on channel 0 alone, conv needs both channels in step
	assign take      = data.word_valid && (op_kind == OP_MAXPOOL || weight.word_valid);
	assign take_last = data.last && (op_kind == OP_MAXPOOL || weight.last);

	assign prod = $signed(data.word) * $signed(weight.word);

	// ------------------------------------------------------------
	// accumulate or keep the running maximum
	// ------------------------------------------------------------
	always_comb begin
		if (op_kind == OP_CONV) begin
			sample = RESULT_W'(prod);                  // sign-extended product
		end else begin
			sample = RESULT_W'($signed(data.word));    // sign-extended activation
		end

		if (first) begin
			next_acc = sample;
		end else if (op_kind == OP_CONV) begin
			next_acc = acc + sample;
		end else begin
			next_acc = (sample > acc) ? sample : acc;
		end
	end

	always_ff @(posedge okClk) begin
		if (take) acc <= next_acc;
		if (take && take_last) result_data <= next_acc;
	end

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			first        <= 1'b1;
			result_valid <= 1'b0;
		end else begin
			if (take) first <= take_last;               // rearm after the last word
			result_valid <= take && take_last;
		end
	end

endmodule

// ==== hw/fetch_channel.sv ====
`timescale 1ns/1ps

module fetch_channel (
	input  logic               okClk,
	input  logic               rst_n,
	input  logic               load_we,
	input  squeeze_pkg::addr_t load_addr,
	input  squeeze_pkg::word_t load_data,
	fetch_if.fetch             chan
);
	import squeeze_pkg::*;

	word_t bank [BANK_DEPTH];
	addr_t walk_addr;      // next address after the one just issued
	len_t  left;           // reads still to issue after the current one
	addr_t rd_addr;
	len_t  rd_left;
	logic  issue;
	logic  issue_last;
	word_t rd_word;
	logic  v1, l1;         // stage 1, aligned with rd_word
	logic  v2, l2;         // stage 2, aligned with chan.word
	word_t word_q;

	// ------------------------------------------------------------
	// address walker
	// ------------------------------------------------------------
	assign rd_addr    = chan.start ? chan.base_addr : walk_addr;
	assign rd_left    = chan.start ? chan.length : left;
	assign issue      = chan.start || (left != '0);
	assign issue_last = (rd_left == LEN_W'(1));

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			left <= '0;
		end else if (issue) begin
			left <= rd_left - 1'b1;
		end
	end

	always_ff @(posedge okClk) begin
		if (issue) walk_addr <= rd_addr + 1'b1;   // wraps modulo bank depth
	end

	// ------------------------------------------------------------
	// bank with registered read, then output register
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (load_we) bank[load_addr] <= load_data;   // host load port
		if (issue)   rd_word <= bank[rd_addr];
		word_q <= rd_word;
	end

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			l1 <= 1'b0;
			v2 <= 1'b0;
			l2 <= 1'b0;
		end else begin
			v1 <= issue;
			l1 <= issue && issue_last;
			v2 <= v1;
			l2 <= l1;
		end
	end

	assign chan.word_valid = v2;
	assign chan.word       = word_q;
	assign chan.last       = l2;

endmodule

// ==== hw/op_dispatcher.sv ====
`timescale 1ns/1ps

module op_dispatcher (
	input  logic                  okClk,
	input  logic                  rst_n,
	input  squeeze_pkg::cmd_t     head,
	input  logic                  empty,
	output logic                  pop,
	fetch_if.issue                ch [squeeze_pkg::N_CH],
	output squeeze_pkg::op_kind_t op_kind,
	input  logic                  done,
	output logic                  busy,
	output logic                  cmd_error
);
	import squeeze_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LAUNCH,
		S_WAIT
	} state_t;

	state_t   state;
	op_kind_t op_q;
	len_t     len_q;
	addr_t    daddr_q;
	addr_t    waddr_q;
	logic     bad_q;       // illegal op code or zero length
	logic     launch;

	// ------------------------------------------------------------
	// command pop and field decode
	// ------------------------------------------------------------
	assign pop = (state == S_IDLE) && !empty;

	always_ff @(posedge okClk) begin
		if (pop) begin
			op_q    <= op_kind_t'(head[OP_MSB:OP_LSB]);
			len_q   <= head[LEN_MSB:LEN_LSB];
			daddr_q <= head[DADDR_MSB:DADDR_LSB];
			waddr_q <= head[WADDR_MSB:WADDR_LSB];
			// op codes 2 and 3 both have the top bit set
			// a zero length would never produce a last word, so it is refused too
			bad_q   <= head[OP_MSB] || (head[LEN_MSB:LEN_LSB] == '0);
		end
	end

	// ------------------------------------------------------------
	// idle -> launch -> wait
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (pop) state <= S_LAUNCH;
				end
				S_LAUNCH: begin
					state <= bad_q ? S_IDLE : S_WAIT;   // rejected op skips wait
				end
				S_WAIT: begin
					if (done) state <= S_IDLE;          // engine emitted its result
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	assign launch    = (state == S_LAUNCH) && !bad_q;
	assign cmd_error = (state == S_LAUNCH) && bad_q;
	assign busy      = launch || (state == S_WAIT);
	assign op_kind   = op_q;

	// data channel always runs
	assign ch[0].start     = launch;
	assign ch[0].base_addr = daddr_q;
	assign ch[0].length    = len_q;

	// weights are only needed for the dot product
	assign ch[1].start     = launch && (op_q == OP_CONV);
	assign ch[1].base_addr = waddr_q;
	assign ch[1].length    = len_q;

endmodule

// ==== hw/cmd_queue.sv ====
`timescale 1ns/1ps

module cmd_queue (
	input  logic              okClk,
	input  logic              rst_n,
	input  logic              push,
	input  squeeze_pkg::cmd_t push_data,
	input  logic              pop,
	output squeeze_pkg::cmd_t head,
	output logic              empty,
	output logic              full
);
	import squeeze_pkg::*;

	cmd_t                 mem [CMD_DEPTH];
	logic [CMD_PTR_W-1:0] wr_ptr;
	logic [CMD_PTR_W-1:0] rd_ptr;
	logic [CMD_CNT_W-1:0] count;
	logic                 do_push;
	logic                 do_pop;

	assign do_push = push && !full;         // a push while full is dropped
	assign do_pop  = pop && !empty;

	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head  = mem[rd_ptr];              // first-word fall-through
	assign empty = (count == '0);
	assign full  = (count == CMD_CNT_W'(CMD_DEPTH));

endmodule

// ==== hw/fetch_if.sv ====
`timescale 1ns/1ps

interface fetch_if;
	import squeeze_pkg::*;

	logic  start;          // one-cycle launch strobe
	addr_t base_addr;
	len_t  length;
	logic  word_valid;     // high for length consecutive cycles
	word_t word;
	logic  last;           // marks the final word of the run

	modport issue   (output start, base_addr, length);

	modport fetch   (input  start, base_addr, length,
	                 output word_valid, word, last);

	modport consume (input  word_valid, word, last);

endinterface

// ==== hw/squeeze_pkg.sv ====
package squeeze_pkg;

	// ------------------------------------------------------------
	// datapath sizes
	// ------------------------------------------------------------
	localparam int N_CH       = 2;              // channel 0 data, channel 1 weights
	localparam int WORD_W     = 8;              // signed activation / weight
	localparam int ADDR_W     = 10;
	localparam int BANK_DEPTH = 1 << ADDR_W;    // 1024 words per bank
	localparam int LEN_W      = 10;             // 1..1023, zero is reserved
	localparam int RESULT_W   = 32;             // exact for 1023 products of 8x8
	localparam int CMD_W      = 32;

	// ------------------------------------------------------------
	// command word layout
	// ------------------------------------------------------------
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 30;
	localparam int LEN_MSB   = 29;
	localparam int LEN_LSB   = 20;
	localparam int DADDR_MSB = 19;              // start of the data run
	localparam int DADDR_LSB = 10;
	localparam int WADDR_MSB = 9;               // start of the weight run
	localparam int WADDR_LSB = 0;

	// command queue sizing
	localparam int CMD_DEPTH = 8;
	localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
	localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

	// codes 2 and 3 are not assigned and get rejected
	typedef enum logic [1:0] {
		OP_CONV    = 2'd0,
		OP_MAXPOOL = 2'd1
	} op_kind_t;

	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [LEN_W-1:0]    len_t;
	typedef logic [RESULT_W-1:0] result_t;
	typedef logic [CMD_W-1:0]    cmd_t;

endpackage
